// ==== source/ti_kbd_pkg.sv ====
// ====================
// TI-99/4A keyboard front end shared types
// Matrix sizes, PS/2 set 2 scancodes, event and
// joystick structs used across the keyboard path
// ====================
`default_nettype none

package ti_kbd_pkg;

	// ====================
	// Matrix geometry
	localparam int NUM_COLS  = 8;
	localparam int NUM_ROWS  = 8;
	localparam int NUM_SEL   = 9;   // Lines 0-7 columns, line 8 Alpha Lock
	localparam int ALPHA_ROW = 4;   // Row pulled low by Alpha Lock

	// One PS/2 event from the host side
	typedef struct packed {
		logic       toggle;   // Flips once per event
		logic       pressed;  // Make 1, break 0
		logic       ext;      // E0 prefix, not used for matching
		logic [7:0] code;     // Set 2 scancode
	} ps2_event_t;

	// One joystick, all bits active high
	typedef struct packed {
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	// Row-major key matrix, 1 = pressed
	typedef logic [NUM_ROWS-1:0][NUM_COLS-1:0] key_matrix_t;

	// ====================
	// Set 2 scancodes, letters
	localparam logic [7:0] SC_A = 8'h1C;
	localparam logic [7:0] SC_B = 8'h32;
	localparam logic [7:0] SC_C = 8'h21;
	localparam logic [7:0] SC_D = 8'h23;
	localparam logic [7:0] SC_E = 8'h24;
	localparam logic [7:0] SC_F = 8'h2B;
	localparam logic [7:0] SC_G = 8'h34;
	localparam logic [7:0] SC_H = 8'h33;
	localparam logic [7:0] SC_I = 8'h43;
	localparam logic [7:0] SC_J = 8'h3B;
	localparam logic [7:0] SC_K = 8'h42;
	localparam logic [7:0] SC_L = 8'h4B;
	localparam logic [7:0] SC_M = 8'h3A;
	localparam logic [7:0] SC_N = 8'h31;
	localparam logic [7:0] SC_O = 8'h44;
	localparam logic [7:0] SC_P = 8'h4D;
	localparam logic [7:0] SC_Q = 8'h15;
	localparam logic [7:0] SC_R = 8'h2D;
	localparam logic [7:0] SC_S = 8'h1B;
	localparam logic [7:0] SC_T = 8'h2C;
	localparam logic [7:0] SC_U = 8'h3C;
	localparam logic [7:0] SC_V = 8'h2A;
	localparam logic [7:0] SC_W = 8'h1D;
	localparam logic [7:0] SC_X = 8'h22;
	localparam logic [7:0] SC_Y = 8'h35;
	localparam logic [7:0] SC_Z = 8'h1A;

	// Digit row
	localparam logic [7:0] SC_0 = 8'h45;
	localparam logic [7:0] SC_1 = 8'h16;
	localparam logic [7:0] SC_2 = 8'h1E;
	localparam logic [7:0] SC_3 = 8'h26;
	localparam logic [7:0] SC_4 = 8'h25;
	localparam logic [7:0] SC_5 = 8'h2E;
	localparam logic [7:0] SC_6 = 8'h36;
	localparam logic [7:0] SC_7 = 8'h3D;
	localparam logic [7:0] SC_8 = 8'h3E;
	localparam logic [7:0] SC_9 = 8'h46;

	// Punctuation
	localparam logic [7:0] SC_MINUS  = 8'h4E;  // Folds onto =
	localparam logic [7:0] SC_EQUALS = 8'h55;
	localparam logic [7:0] SC_BSLASH = 8'h5D;  // Folds onto =
	localparam logic [7:0] SC_LBRACK = 8'h54;  // Folds onto /
	localparam logic [7:0] SC_SLASH  = 8'h4A;
	localparam logic [7:0] SC_SEMI   = 8'h4C;
	localparam logic [7:0] SC_COMMA  = 8'h41;
	localparam logic [7:0] SC_PERIOD = 8'h49;
	localparam logic [7:0] SC_QUOTE  = 8'h52;  // Fn+P
	localparam logic [7:0] SC_BTICK  = 8'h0E;  // Virtual fire

	// Modifiers and editing keys
	localparam logic [7:0] SC_ENTER  = 8'h5A;
	localparam logic [7:0] SC_SPACE  = 8'h29;
	localparam logic [7:0] SC_LSHIFT = 8'h12;
	localparam logic [7:0] SC_RSHIFT = 8'h59;
	localparam logic [7:0] SC_CTRL   = 8'h14;
	localparam logic [7:0] SC_ALT    = 8'h11;  // Fn
	localparam logic [7:0] SC_CAPS   = 8'h58;  // Alpha Lock toggle
	localparam logic [7:0] SC_BKSP   = 8'h66;  // Fn+S
	localparam logic [7:0] SC_DEL    = 8'h71;  // Fn+1
	localparam logic [7:0] SC_INS    = 8'h70;  // Fn+2
	localparam logic [7:0] SC_ESC    = 8'h76;  // Fn+9

	// Arrows, E0 prefixed on the wire
	localparam logic [7:0] SC_UP    = 8'h75;
	localparam logic [7:0] SC_DOWN  = 8'h72;
	localparam logic [7:0] SC_LEFT  = 8'h6B;
	localparam logic [7:0] SC_RIGHT = 8'h74;

endpackage

`default_nettype wire

// ==== source/ps2_key_decoder.sv ====
// ====================
// PS/2 key event decoder
// Tracks pressed keys in the TI matrix layout,
// builds the virtual joystick from the arrows
// and toggles Alpha Lock from Caps Lock
// ====================
`timescale 1ns/1ps
`default_nettype none

module ps2_key_decoder (
	input  wire                          clk_sys,
	input  wire                          RESET,
	input  wire ti_kbd_pkg::ps2_event_t  ps2_key_i,
	input  wire                          virt_joy_i,
	output ti_kbd_pkg::key_matrix_t      key_state_o,
	output ti_kbd_pkg::joy_t             vjoy_o,
	output logic                         alpha_lock_o
);

	// Fn key position, shared by all combined keys
	localparam int FN_R = 4;
	localparam int FN_C = 7;

	logic                    toggle_q;   // Toggle seen at last edge
	logic                    event_new;
	logic                    pr;         // Make or break of current event
	ti_kbd_pkg::key_matrix_t keys_q;
	ti_kbd_pkg::key_matrix_t keys_d;
	ti_kbd_pkg::joy_t        vjoy_q;
	ti_kbd_pkg::joy_t        vjoy_d;
	logic                    alpha_q;
	logic                    alpha_d;

	assign event_new = ps2_key_i.toggle ^ toggle_q;
	assign pr        = ps2_key_i.pressed;

	// ====================
	// Next state from the scancode
	always_comb begin
		keys_d  = keys_q;
		vjoy_d  = vjoy_q;
		alpha_d = alpha_q;
		if (event_new) begin
			case (ps2_key_i.code)   // ext bit ignored on purpose
				// Row 0
				ti_kbd_pkg::SC_EQUALS: keys_d[0][7] = pr;
				ti_kbd_pkg::SC_MINUS:  keys_d[0][7] = pr;
				ti_kbd_pkg::SC_BSLASH: keys_d[0][7] = pr;
				ti_kbd_pkg::SC_PERIOD: keys_d[0][6] = pr;
				ti_kbd_pkg::SC_COMMA:  keys_d[0][5] = pr;
				ti_kbd_pkg::SC_M:      keys_d[0][4] = pr;
				ti_kbd_pkg::SC_N:      keys_d[0][3] = pr;
				ti_kbd_pkg::SC_SLASH:  keys_d[0][2] = pr;
				ti_kbd_pkg::SC_LBRACK: keys_d[0][2] = pr;
				// Row 1
				ti_kbd_pkg::SC_SPACE:  keys_d[1][7] = pr;
				ti_kbd_pkg::SC_L:      keys_d[1][6] = pr;
				ti_kbd_pkg::SC_K:      keys_d[1][5] = pr;
				ti_kbd_pkg::SC_J:      keys_d[1][4] = pr;
				ti_kbd_pkg::SC_H:      keys_d[1][3] = pr;
				ti_kbd_pkg::SC_SEMI:   keys_d[1][2] = pr;
				// Row 2
				ti_kbd_pkg::SC_ENTER:  keys_d[2][7] = pr;
				ti_kbd_pkg::SC_O:      keys_d[2][6] = pr;
				ti_kbd_pkg::SC_I:      keys_d[2][5] = pr;
				ti_kbd_pkg::SC_U:      keys_d[2][4] = pr;
				ti_kbd_pkg::SC_Y:      keys_d[2][3] = pr;
				ti_kbd_pkg::SC_P:      keys_d[2][2] = pr;
				// Row 3, col 7 unused
				ti_kbd_pkg::SC_9:      keys_d[3][6] = pr;
				ti_kbd_pkg::SC_8:      keys_d[3][5] = pr;
				ti_kbd_pkg::SC_7:      keys_d[3][4] = pr;
				ti_kbd_pkg::SC_6:      keys_d[3][3] = pr;
				ti_kbd_pkg::SC_0:      keys_d[3][2] = pr;
				// Row 4
				ti_kbd_pkg::SC_ALT:    keys_d[FN_R][FN_C] = pr;
				ti_kbd_pkg::SC_2:      keys_d[4][6] = pr;
				ti_kbd_pkg::SC_3:      keys_d[4][5] = pr;
				ti_kbd_pkg::SC_4:      keys_d[4][4] = pr;
				ti_kbd_pkg::SC_5:      keys_d[4][3] = pr;
				ti_kbd_pkg::SC_1:      keys_d[4][2] = pr;
				// Row 5, both shifts land on one key
				ti_kbd_pkg::SC_LSHIFT: keys_d[5][7] = pr;
				ti_kbd_pkg::SC_RSHIFT: keys_d[5][7] = pr;
				ti_kbd_pkg::SC_S:      keys_d[5][6] = pr;
				ti_kbd_pkg::SC_D:      keys_d[5][5] = pr;
				ti_kbd_pkg::SC_F:      keys_d[5][4] = pr;
				ti_kbd_pkg::SC_G:      keys_d[5][3] = pr;
				ti_kbd_pkg::SC_A:      keys_d[5][2] = pr;
				// Row 6
				ti_kbd_pkg::SC_CTRL:   keys_d[6][7] = pr;
				ti_kbd_pkg::SC_W:      keys_d[6][6] = pr;
				ti_kbd_pkg::SC_E:      keys_d[6][5] = pr;
				ti_kbd_pkg::SC_R:      keys_d[6][4] = pr;
				ti_kbd_pkg::SC_T:      keys_d[6][3] = pr;
				ti_kbd_pkg::SC_Q:      keys_d[6][2] = pr;
				// Row 7, col 7 unused
				ti_kbd_pkg::SC_X:      keys_d[7][6] = pr;
				ti_kbd_pkg::SC_C:      keys_d[7][5] = pr;
				ti_kbd_pkg::SC_V:      keys_d[7][4] = pr;
				ti_kbd_pkg::SC_B:      keys_d[7][3] = pr;
				ti_kbd_pkg::SC_Z:      keys_d[7][2] = pr;

				// ====================
				// Combined keys, Fn plus one more
				ti_kbd_pkg::SC_QUOTE: begin
					keys_d[FN_R][FN_C] = pr;
					keys_d[2][2]       = pr;   // P
				end
				ti_kbd_pkg::SC_BKSP: begin
					keys_d[FN_R][FN_C] = pr;
					keys_d[5][6]       = pr;   // S
				end
				ti_kbd_pkg::SC_DEL: begin
					keys_d[FN_R][FN_C] = pr;
					keys_d[4][2]       = pr;   // 1
				end
				ti_kbd_pkg::SC_INS: begin
					keys_d[FN_R][FN_C] = pr;
					keys_d[4][6]       = pr;   // 2
				end
				ti_kbd_pkg::SC_ESC: begin
					keys_d[FN_R][FN_C] = pr;
					keys_d[3][6]       = pr;   // 9
				end

				// Arrows go to joystick or to Fn+E/S/D/X
				ti_kbd_pkg::SC_UP: begin
					if (virt_joy_i) begin
						vjoy_d.up = pr;
					end else begin
						keys_d[FN_R][FN_C] = pr;
						keys_d[6][5]       = pr;   // E
					end
				end
				ti_kbd_pkg::SC_LEFT: begin
					if (virt_joy_i) begin
						vjoy_d.left = pr;
					end else begin
						keys_d[FN_R][FN_C] = pr;
						keys_d[5][6]       = pr;   // S
					end
				end
				ti_kbd_pkg::SC_RIGHT: begin
					if (virt_joy_i) begin
						vjoy_d.right = pr;
					end else begin
						keys_d[FN_R][FN_C] = pr;
						keys_d[5][5]       = pr;   // D
					end
				end
				ti_kbd_pkg::SC_DOWN: begin
					if (virt_joy_i) begin
						vjoy_d.down = pr;
					end else begin
						keys_d[FN_R][FN_C] = pr;
						keys_d[7][6]       = pr;   // X
					end
				end
				ti_kbd_pkg::SC_BTICK: vjoy_d.fire = pr;   // Fire in either mode

				// Caps Lock flips on make only
				ti_kbd_pkg::SC_CAPS: begin
					if (pr) begin
						alpha_d = ~alpha_q;
					end
				end
				default: ;
			endcase
		end
	end

	// ====================
	// State registers
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			toggle_q <= 1'b0;
			keys_q   <= '0;
			vjoy_q   <= '0;
			alpha_q  <= 1'b0;
		end else begin
			toggle_q <= ps2_key_i.toggle;
			keys_q   <= keys_d;
			vjoy_q   <= vjoy_d;
			alpha_q  <= alpha_d;
		end
	end

	assign key_state_o  = keys_q;
	assign vjoy_o       = vjoy_q;
	assign alpha_lock_o = alpha_q;

endmodule

`default_nettype wire

// ==== source/joystick_merge.sv ====
// ====================
// Joystick merge stage
// Swaps the two ports, ORs the virtual joystick
// into port 1 and registers the full matrix
// ====================
`timescale 1ns/1ps
`default_nettype none

module joystick_merge (
	input  wire                           clk_sys,
	input  wire                           RESET,
	input  wire ti_kbd_pkg::key_matrix_t  key_state_i,
	input  wire ti_kbd_pkg::joy_t         vjoy_i,
	input  wire ti_kbd_pkg::joy_t         joy0_i,
	input  wire ti_kbd_pkg::joy_t         joy1_i,
	input  wire                           joy_swap_i,
	output ti_kbd_pkg::key_matrix_t       merged_keys_o
);

	ti_kbd_pkg::joy_t        port1;
	ti_kbd_pkg::joy_t        port2;
	logic [4:0]              p1_col;     // Column 1 bits, row 4 down to 0
	logic [4:0]              p2_col;     // Column 0 bits
	ti_kbd_pkg::key_matrix_t merged_d;

	// Joystick bits in row order: up, down, right, left, fire
	function automatic logic [4:0] joy_column(input ti_kbd_pkg::joy_t j);
		joy_column = {j.up, j.down, j.right, j.left, j.fire};
	endfunction

	// Port select and virtual stick merge
	always_comb begin
		port1 = joy_swap_i ? joy1_i : joy0_i;
		port1 = port1 | vjoy_i;              // Arrows act on port 1 only
		port2 = joy_swap_i ? joy0_i : joy1_i;
	end

	assign p1_col = joy_column(port1);
	assign p2_col = joy_column(port2);

	// ====================
	// Drop joystick bits into columns 1 and 0
	always_comb begin
		merged_d = key_state_i;
		for (int r = 0; r < 5; r++) begin
			merged_d[r][1] = p1_col[r];
			merged_d[r][0] = p2_col[r];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			merged_keys_o <= '0;
		end else begin
			merged_keys_o <= merged_d;
		end
	end

endmodule

`default_nettype wire

// ==== source/key_matrix_scan.sv ====
// ====================
// Key matrix scan
// Console drives column selects low, rows answer
// low for any pressed key in a selected column
// ====================
`timescale 1ns/1ps
`default_nettype none

module key_matrix_scan (
	input  wire ti_kbd_pkg::key_matrix_t          merged_keys_i,
	input  wire                                   alpha_lock_i,
	input  wire [ti_kbd_pkg::NUM_SEL-1:0]         col_sel_n_i,
	output logic [ti_kbd_pkg::NUM_ROWS-1:0]       row_n_o
);

	logic [ti_kbd_pkg::NUM_COLS-1:0] col_en;     // Active high column enables
	logic                            alpha_sel;

	// ====================
	// Select line to column remap
	// Lines 0-3 straight, lines 4-7 reversed onto cols 7-4
	always_comb begin
		col_en[3:0] = ~col_sel_n_i[3:0];
		col_en[7]   = ~col_sel_n_i[4];
		col_en[6]   = ~col_sel_n_i[5];
		col_en[5]   = ~col_sel_n_i[6];
		col_en[4]   = ~col_sel_n_i[7];
	end

	// Extra select line reads Alpha Lock
	assign alpha_sel = alpha_lock_i & ~col_sel_n_i[ti_kbd_pkg::NUM_SEL-1];

	// ====================
	// Row drivers, active low
	always_comb begin
		for (int r = 0; r < ti_kbd_pkg::NUM_ROWS; r++) begin
			row_n_o[r] = ~|(merged_keys_i[r] & col_en);
			if (r == ti_kbd_pkg::ALPHA_ROW && alpha_sel) begin
				row_n_o[r] = 1'b0;   // Alpha Lock shares row 4
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/ti_keyboard_top.sv ====
// ====================
// TI-99/4A keyboard and joystick front end
// PS/2 decode, joystick merge and matrix scan
// ====================
`timescale 1ns/1ps
`default_nettype none

module ti_keyboard_top (
	input  wire                                clk_sys,
	input  wire                                RESET,
	input  wire ti_kbd_pkg::ps2_event_t        ps2_key_i,
	input  wire                                virt_joy_i,
	input  wire                                joy_swap_i,
	input  wire ti_kbd_pkg::joy_t              joy0_i,
	input  wire ti_kbd_pkg::joy_t              joy1_i,
	input  wire [ti_kbd_pkg::NUM_SEL-1:0]      col_sel_n_i,
	output wire [ti_kbd_pkg::NUM_ROWS-1:0]     row_n_o
);

	ti_kbd_pkg::key_matrix_t key_state;     // Keyboard keys only
	ti_kbd_pkg::joy_t        vjoy;          // Arrow keys as stick
	logic                    alpha_lock;
	ti_kbd_pkg::key_matrix_t merged_keys;   // Keys plus both ports

	// PS/2 side, one cycle after an event
	ps2_key_decoder i_decoder (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.ps2_key_i    (ps2_key_i),
		.virt_joy_i   (virt_joy_i),
		.key_state_o  (key_state),
		.vjoy_o       (vjoy),
		.alpha_lock_o (alpha_lock)
	);

	// Registered full matrix
	joystick_merge i_merge (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.key_state_i   (key_state),
		.vjoy_i        (vjoy),
		.joy0_i        (joy0_i),
		.joy1_i        (joy1_i),
		.joy_swap_i    (joy_swap_i),
		.merged_keys_o (merged_keys)
	);

	// Combinational row answer
	key_matrix_scan i_scan (
		.merged_keys_i (merged_keys),
		.alpha_lock_i  (alpha_lock),
		.col_sel_n_i   (col_sel_n_i),
		.row_n_o       (row_n_o)
	);

endmodule

`default_nettype wire

// ==== tb/ti_keyboard_sva.sv ====
// ====================
// Row output assertions for the keyboard top level
// ====================
`timescale 1ns/1ps
`default_nettype none

module ti_keyboard_sva (
	input wire                            clk_sys,
	input wire                            RESET,
	input wire [ti_kbd_pkg::NUM_SEL-1:0]  col_sel_n_i,
	input wire [ti_kbd_pkg::NUM_ROWS-1:0] row_n_o
);

	// Alpha Lock row may answer to line 8 alone
	localparam logic [7:0] ALPHA_MASK = 8'h01 << ti_kbd_pkg::ALPHA_ROW;

	// Nothing selected, nothing pulled low
	a_idle_rows: assert property (@(posedge clk_sys) disable iff (RESET)
		(&col_sel_n_i) |-> (&row_n_o))
		else $error("row low with all select lines high");

	a_no_x: assert property (@(posedge clk_sys) disable iff (RESET)
		!$isunknown(row_n_o))
		else $error("unknown bits on row_n_o");

	// Only Alpha Lock without a column
	a_cols_off: assert property (@(posedge clk_sys) disable iff (RESET)
		(&col_sel_n_i[7:0]) |-> (&(row_n_o | ALPHA_MASK)))
		else $error("non alpha row low with no column selected");

endmodule

bind ti_keyboard_top ti_keyboard_sva i_sva (
	.clk_sys     (clk_sys),
	.RESET       (RESET),
	.col_sel_n_i (col_sel_n_i),
	.row_n_o     (row_n_o)
);

`default_nettype wire

// ==== tb/tb_ti_keyboard.sv ====
// ====================
// Testbench for the TI-99/4A keyboard front end
// LFSR driven PS/2 events, joysticks and column
// selects, checked against a model of the matrix
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_ti_keyboard;

	localparam int NKEYS      = 61;
	localparam int N_RAND     = 200;
	localparam int N_JOY      = 100;
	localparam int N_MULTI    = 40;
	localparam int MAX_CYCLES = 400 * 8 + 800;   // ~400 events of ~8 cycles, plus setup
	localparam int K_KEY      = 0;   // Single key
	localparam int K_FN       = 1;   // Fn plus key
	localparam int K_ARROW    = 2;   // Stick bit or Fn plus key
	localparam int K_MISC     = 3;   // Backtick, Caps Lock

	// Select line to column, lines 4-7 land reversed
	localparam logic [2:0] SEL_COL [8] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd7, 3'd6, 3'd5, 3'd4};

	logic                            clk_sys;
	logic                            RESET;
	ti_kbd_pkg::ps2_event_t          ps2_key;
	logic                            virt_joy;
	logic                            joy_swap;
	ti_kbd_pkg::joy_t                joy0;
	ti_kbd_pkg::joy_t                joy1;
	logic [ti_kbd_pkg::NUM_SEL-1:0]  col_sel_n;
	wire  [ti_kbd_pkg::NUM_ROWS-1:0] row_n;

	// Model state
	ti_kbd_pkg::key_matrix_t m_keys;
	ti_kbd_pkg::joy_t        m_vjoy;
	ti_kbd_pkg::joy_t        m_joy0;
	ti_kbd_pkg::joy_t        m_joy1;
	logic                    m_swap;
	logic                    m_alpha;

	logic [15:0] key_tab [NKEYS];   // {code, kind, row, col}
	logic [31:0] lfsr;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;

	ti_keyboard_top i_dut (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.ps2_key_i   (ps2_key),
		.virt_joy_i  (virt_joy),
		.joy_swap_i  (joy_swap),
		.joy0_i      (joy0),
		.joy1_i      (joy1),
		.col_sel_n_i (col_sel_n),
		.row_n_o     (row_n)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;   // 40 ns period
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	// ====================
	// Random source, Galois LFSR
	function automatic logic rand_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], rand_bit()};   // One step per bit
		end
		return v;
	endfunction

	function automatic logic [15:0] ent(input logic [7:0] code, input int kind,
		input int row, input int col);
		return {code, kind[1:0], row[2:0], col[2:0]};
	endfunction

	// Every mapped scancode, by layout row
	task automatic fill_table();
		key_tab = '{
			ent(ti_kbd_pkg::SC_EQUALS, K_KEY, 0, 7), ent(ti_kbd_pkg::SC_MINUS, K_KEY, 0, 7),
			ent(ti_kbd_pkg::SC_BSLASH, K_KEY, 0, 7), ent(ti_kbd_pkg::SC_PERIOD, K_KEY, 0, 6),
			ent(ti_kbd_pkg::SC_COMMA, K_KEY, 0, 5), ent(ti_kbd_pkg::SC_M, K_KEY, 0, 4),
			ent(ti_kbd_pkg::SC_N, K_KEY, 0, 3), ent(ti_kbd_pkg::SC_SLASH, K_KEY, 0, 2),
			ent(ti_kbd_pkg::SC_LBRACK, K_KEY, 0, 2), ent(ti_kbd_pkg::SC_SPACE, K_KEY, 1, 7),
			ent(ti_kbd_pkg::SC_L, K_KEY, 1, 6), ent(ti_kbd_pkg::SC_K, K_KEY, 1, 5),
			ent(ti_kbd_pkg::SC_J, K_KEY, 1, 4), ent(ti_kbd_pkg::SC_H, K_KEY, 1, 3),
			ent(ti_kbd_pkg::SC_SEMI, K_KEY, 1, 2), ent(ti_kbd_pkg::SC_ENTER, K_KEY, 2, 7),
			ent(ti_kbd_pkg::SC_O, K_KEY, 2, 6), ent(ti_kbd_pkg::SC_I, K_KEY, 2, 5),
			ent(ti_kbd_pkg::SC_U, K_KEY, 2, 4), ent(ti_kbd_pkg::SC_Y, K_KEY, 2, 3),
			ent(ti_kbd_pkg::SC_P, K_KEY, 2, 2), ent(ti_kbd_pkg::SC_9, K_KEY, 3, 6),
			ent(ti_kbd_pkg::SC_8, K_KEY, 3, 5), ent(ti_kbd_pkg::SC_7, K_KEY, 3, 4),
			ent(ti_kbd_pkg::SC_6, K_KEY, 3, 3), ent(ti_kbd_pkg::SC_0, K_KEY, 3, 2),
			ent(ti_kbd_pkg::SC_ALT, K_KEY, 4, 7), ent(ti_kbd_pkg::SC_2, K_KEY, 4, 6),
			ent(ti_kbd_pkg::SC_3, K_KEY, 4, 5), ent(ti_kbd_pkg::SC_4, K_KEY, 4, 4),
			ent(ti_kbd_pkg::SC_5, K_KEY, 4, 3), ent(ti_kbd_pkg::SC_1, K_KEY, 4, 2),
			ent(ti_kbd_pkg::SC_LSHIFT, K_KEY, 5, 7), ent(ti_kbd_pkg::SC_RSHIFT, K_KEY, 5, 7),
			ent(ti_kbd_pkg::SC_S, K_KEY, 5, 6), ent(ti_kbd_pkg::SC_D, K_KEY, 5, 5),
			ent(ti_kbd_pkg::SC_F, K_KEY, 5, 4), ent(ti_kbd_pkg::SC_G, K_KEY, 5, 3),
			ent(ti_kbd_pkg::SC_A, K_KEY, 5, 2), ent(ti_kbd_pkg::SC_CTRL, K_KEY, 6, 7),
			ent(ti_kbd_pkg::SC_W, K_KEY, 6, 6), ent(ti_kbd_pkg::SC_E, K_KEY, 6, 5),
			ent(ti_kbd_pkg::SC_R, K_KEY, 6, 4), ent(ti_kbd_pkg::SC_T, K_KEY, 6, 3),
			ent(ti_kbd_pkg::SC_Q, K_KEY, 6, 2), ent(ti_kbd_pkg::SC_X, K_KEY, 7, 6),
			ent(ti_kbd_pkg::SC_C, K_KEY, 7, 5), ent(ti_kbd_pkg::SC_V, K_KEY, 7, 4),
			ent(ti_kbd_pkg::SC_B, K_KEY, 7, 3), ent(ti_kbd_pkg::SC_Z, K_KEY, 7, 2),
			ent(ti_kbd_pkg::SC_QUOTE, K_FN, 2, 2), ent(ti_kbd_pkg::SC_BKSP, K_FN, 5, 6),
			ent(ti_kbd_pkg::SC_DEL, K_FN, 4, 2), ent(ti_kbd_pkg::SC_INS, K_FN, 4, 6),
			ent(ti_kbd_pkg::SC_ESC, K_FN, 3, 6), ent(ti_kbd_pkg::SC_UP, K_ARROW, 6, 5),
			ent(ti_kbd_pkg::SC_LEFT, K_ARROW, 5, 6), ent(ti_kbd_pkg::SC_RIGHT, K_ARROW, 5, 5),
			ent(ti_kbd_pkg::SC_DOWN, K_ARROW, 7, 6), ent(ti_kbd_pkg::SC_BTICK, K_MISC, 0, 0),
			ent(ti_kbd_pkg::SC_CAPS, K_MISC, 0, 0)
		};
	endtask

	// ====================
	// Reference model
	task automatic apply_event(input logic [15:0] e, input logic pr, input logic vj);
		logic [7:0] code;
		logic [1:0] kind;
		logic [2:0] r;
		logic [2:0] c;
		code = e[15:8];
		kind = e[7:6];
		r    = e[5:3];
		c    = e[2:0];
		if (kind == 2'd0) begin
			m_keys[r][c] = pr;
		end else if (kind == 2'd1 || (kind == 2'd2 && !vj)) begin
			m_keys[4][7] = pr;   // Fn
			m_keys[r][c] = pr;
		end else if (kind == 2'd2) begin
			case (code)
				ti_kbd_pkg::SC_UP:   m_vjoy.up   = pr;
				ti_kbd_pkg::SC_DOWN: m_vjoy.down = pr;
				ti_kbd_pkg::SC_LEFT: m_vjoy.left = pr;
				default:             m_vjoy.right = pr;
			endcase
		end else if (code == ti_kbd_pkg::SC_CAPS) begin
			if (pr) begin
				m_alpha = ~m_alpha;   // Make only
			end
		end else begin
			m_vjoy.fire = pr;
		end
	endtask

	function automatic logic [7:0] expect_rows(input logic [8:0] sel_n);
		ti_kbd_pkg::key_matrix_t full;
		ti_kbd_pkg::joy_t        p1;
		ti_kbd_pkg::joy_t        p2;
		logic [7:0]              rows;
		int                      s;
		int                      r;
		full = m_keys;
		p1   = m_swap ? m_joy1 : m_joy0;
		p1   = p1 | m_vjoy;   // Arrows on port 1
		p2   = m_swap ? m_joy0 : m_joy1;
		full[0][1:0] = {p1.fire, p2.fire};
		full[1][1:0] = {p1.left, p2.left};
		full[2][1:0] = {p1.right, p2.right};
		full[3][1:0] = {p1.down, p2.down};
		full[4][1:0] = {p1.up, p2.up};
		rows = 8'hFF;
		for (s = 0; s < 8; s++) begin
			for (r = 0; r < 8; r++) begin
				if (!sel_n[s] && full[r][SEL_COL[s]]) begin
					rows[r] = 1'b0;
				end
			end
		end
		if (m_alpha && !sel_n[8]) begin
			rows[ti_kbd_pkg::ALPHA_ROW] = 1'b0;
		end
		return rows;
	endfunction

	task automatic clear_model();
		m_keys  = '0;
		m_vjoy  = '0;
		m_joy0  = '0;
		m_joy1  = '0;
		m_swap  = 1'b0;
		m_alpha = 1'b0;
	endtask

	// ====================
	// Drivers and checks
	task automatic check_rows(input string what);
		logic [7:0] exp;
		exp = expect_rows(col_sel_n);
		checks++;
		if (row_n !== exp) begin
			errors++;
			$display("Fail %0d ns: %s, row_n_o %b expected %b, select %b",
				$time, what, row_n, exp, col_sel_n);
		end
	endtask

	task automatic check_sel(input logic [8:0] sel, input string what);
		@(posedge clk_sys);
		col_sel_n <= sel;
		@(negedge clk_sys);   // Scan is combinational
		check_rows(what);
	endtask

	task automatic sweep_selects(input string what);
		int s;
		for (s = 0; s < 9; s++) begin
			check_sel(~(9'd1 << s), what);
		end
	endtask

	// Event at edge N shows after edge N+2
	task automatic send_event(input logic [15:0] e, input logic pr, input logic vj,
		input logic [8:0] sel);
		logic ext_bit;
		ext_bit = rand_bit();   // E0 flag, must not matter
		@(posedge clk_sys);
		ps2_key   <= {~ps2_key.toggle, pr, ext_bit, e[15:8]};
		virt_joy  <= vj;
		col_sel_n <= sel;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		apply_event(e, pr, vj);
		check_rows($sformatf("code %h %s", e[15:8], pr ? "make" : "break"));
	endtask

	task automatic drive_joy(input logic [4:0] j0, input logic [4:0] j1, input logic sw,
		input logic [8:0] sel);
		@(posedge clk_sys);
		joy0      <= j0;
		joy1      <= j1;
		joy_swap  <= sw;
		col_sel_n <= sel;
		@(posedge clk_sys);   // One register stage
		@(negedge clk_sys);
		m_joy0 = j0;
		m_joy1 = j1;
		m_swap = sw;
		check_rows("joystick merge");
	endtask

	task automatic do_reset();
		@(posedge clk_sys);
		RESET    <= 1'b1;
		ps2_key  <= '0;   // Toggle back to its reset value
		virt_joy <= 1'b0;
		joy_swap <= 1'b0;
		joy0     <= '0;
		joy1     <= '0;
		repeat (3) @(posedge clk_sys);
		RESET <= 1'b0;
		clear_model();
	endtask

	// ====================
	// Test sequence
	initial begin
		logic [31:0] v;
		int          k;
		int          idx;
		int          vjm;
		lfsr      = 32'd85627;
		RESET     = 1'b1;
		ps2_key   = '0;
		virt_joy  = 1'b0;
		joy_swap  = 1'b0;
		joy0      = '0;
		joy1      = '0;
		col_sel_n = '1;
		fill_table();
		clear_model();
		repeat (3) @(posedge clk_sys);
		RESET <= 1'b0;

		check_sel(9'h000, "idle after reset");   // All lines low, nothing pressed

		// Random single keys, select lines in turn
		for (k = 0; k < N_RAND; k++) begin
			v   = rand_bits(6);
			idx = v % NKEYS;
			send_event(key_tab[idx], rand_bit(), rand_bit(), ~(9'd1 << (k % 9)));
		end

		// Combined keys and arrows in both modes
		do_reset();
		for (vjm = 0; vjm < 2; vjm++) begin
			for (idx = 0; idx < NKEYS; idx++) begin
				if (key_tab[idx][7:6] == 2'd1 || key_tab[idx][7:6] == 2'd2) begin
					send_event(key_tab[idx], 1'b1, vjm[0], 9'h000);
					sweep_selects("combined key held");
					send_event(key_tab[idx], 1'b0, vjm[0], 9'h000);
				end
			end
		end

		// Caps Lock, line 8 alone then lines 0-7 alone
		for (k = 0; k < 12; k++) begin
			send_event(ent(ti_kbd_pkg::SC_CAPS, K_MISC, 0, 0), rand_bit(), 1'b0, 9'h0FF);
			check_sel(9'h100, "alpha lock with line 8 high");
		end

		// Joysticks and swap, virtual up and fire held
		send_event(ent(ti_kbd_pkg::SC_UP, K_ARROW, 6, 5), 1'b1, 1'b1, 9'h1FC);
		send_event(ent(ti_kbd_pkg::SC_BTICK, K_MISC, 0, 0), 1'b1, 1'b1, 9'h1FC);
		for (k = 0; k < N_JOY; k++) begin
			v = rand_bits(11);
			drive_joy(v[4:0], v[9:5], v[10], (k % 2 == 1) ? 9'h1FE : 9'h1FD);
		end

		// Several lines low at once
		for (k = 0; k < 10; k++) begin
			v = rand_bits(6);
			send_event(key_tab[v % NKEYS], 1'b1, 1'b0, 9'h1FF);
		end
		for (k = 0; k < N_MULTI; k++) begin
			v = rand_bits(9);
			check_sel(v[8:0], "multiple select lines");
		end

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
source/ti_kbd_pkg.sv
source/ps2_key_decoder.sv
source/joystick_merge.sv
source/key_matrix_scan.sv
source/ti_keyboard_top.sv
tb/ti_keyboard_sva.sv
tb/tb_ti_keyboard.sv

// ==== Makefile ====
# Verilator build and run of the keyboard front end testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_ti_keyboard -f tb.f -o tb_sim
	out="$$(./obj_dir/tb_sim)"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
